// ==== files.f ====
+incdir+testbench
logic/pulp_soc_pkg.sv
logic/soc_bus_arbiter.sv
logic/soc_bus_demux.sv
logic/l2_mem.sv
logic/soc_peripherals.sv
logic/pulp_soc.sv
testbench/tb_pulp_soc.sv

// ==== logic/l2_mem.sv ====
/*
 * L2 memory
 * word array with byte-enabled writes and a registered read,
 * answering one cycle after each request
 */

`timescale 1ns/1ns

module l2_mem #(
  parameter  int unsigned L2_N_WORDS = 256,
  localparam int unsigned WORD_W     = $clog2(L2_N_WORDS)
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic        [WORD_W-1:0] word_i,
  input  pulp_soc_pkg::data_t      wdata_i,
  input  pulp_soc_pkg::be_t        be_i,
  output logic                     rsp_o,
  output pulp_soc_pkg::data_t      rdata_o
);
  import pulp_soc_pkg::*;

  data_t mem_q [L2_N_WORDS];

  // contents start cleared
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int w = 0; w < L2_N_WORDS; w++) begin
        mem_q[w] <= '0;
      end
      rsp_o <= 1'b0;
    end else begin
      rsp_o <= req_i;
      if (req_i && we_i) begin
        for (int b = 0; b < DATA_W / 8; b++) begin
          if (be_i[b]) begin
            mem_q[word_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  // write responses carry the old word
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= mem_q[word_i];
    end
  end

  // word_i spans exactly L2_N_WORDS, so any known index is in range
  a_word_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i |-> !$isunknown(word_i));

endmodule

// ==== logic/pulp_soc.sv ====
/*
 * pulp soc top level
 * cluster and host masters share one bus through a round-robin
 * arbiter, decoded onto L2 and the peripheral block
 */

`timescale 1ns/1ns

module pulp_soc #(
  parameter  int unsigned N_CLUSTERS = 2,
  parameter  int unsigned L2_N_WORDS = 256,
  localparam int unsigned N_MST      = N_CLUSTERS + 1
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                [N_MST-1:0]    mst_req_i,
  input  logic                [N_MST-1:0]    mst_we_i,
  input  pulp_soc_pkg::addr_t [N_MST-1:0]    mst_addr_i,
  input  pulp_soc_pkg::data_t [N_MST-1:0]    mst_wdata_i,
  input  pulp_soc_pkg::be_t   [N_MST-1:0]    mst_be_i,
  output logic                [N_MST-1:0]    mst_rsp_o,
  output pulp_soc_pkg::data_t [N_MST-1:0]    mst_rdata_o,
  output logic                [N_MST-1:0]    mst_err_o,
  output logic                [N_CLUSTERS-1:0] cl_eoc_o,
  output logic                [N_CLUSTERS-1:0] cl_busy_o
);
  import pulp_soc_pkg::*;

  localparam int unsigned MST_W  = $clog2(N_MST);
  localparam int unsigned WORD_W = $clog2(L2_N_WORDS);
  localparam int unsigned OFFS_W = $clog2(PERIPH_N_BYTES);

  // shared bus
  logic              bus_req;
  logic              bus_we;
  addr_t             bus_addr;
  data_t             bus_wdata;
  be_t               bus_be;
  logic  [MST_W-1:0] bus_mst;
  logic  [N_MST-1:0] mst_busy;

  // L2 port
  logic               l2_req;
  logic               l2_we;
  logic  [WORD_W-1:0] l2_word;
  data_t              l2_wdata;
  be_t                l2_be;
  logic               l2_rsp;
  data_t              l2_rdata;

  // peripheral port
  logic               periph_req;
  logic               periph_we;
  logic  [OFFS_W-1:0] periph_offs;
  data_t              periph_wdata;
  be_t                periph_be;
  logic               periph_rsp;
  data_t              periph_rdata;

  // host is the top master index, not reported as busy
  assign cl_busy_o = mst_busy[N_CLUSTERS-1:0];

  soc_bus_arbiter #(
    .N_CLUSTERS (N_CLUSTERS)
  ) i_arbiter (
    .clk_i,
    .rst_i,
    .mst_req_i,
    .mst_we_i,
    .mst_addr_i,
    .mst_wdata_i,
    .mst_be_i,
    .mst_rsp_i   (mst_rsp_o),
    .bus_req_o   (bus_req),
    .bus_we_o    (bus_we),
    .bus_addr_o  (bus_addr),
    .bus_wdata_o (bus_wdata),
    .bus_be_o    (bus_be),
    .bus_mst_o   (bus_mst),
    .mst_busy_o  (mst_busy)
  );

  soc_bus_demux #(
    .N_CLUSTERS (N_CLUSTERS),
    .L2_N_WORDS (L2_N_WORDS)
  ) i_demux (
    .clk_i,
    .rst_i,
    .bus_req_i      (bus_req),
    .bus_we_i       (bus_we),
    .bus_addr_i     (bus_addr),
    .bus_wdata_i    (bus_wdata),
    .bus_be_i       (bus_be),
    .bus_mst_i      (bus_mst),
    .l2_req_o       (l2_req),
    .l2_we_o        (l2_we),
    .l2_word_o      (l2_word),
    .l2_wdata_o     (l2_wdata),
    .l2_be_o        (l2_be),
    .l2_rsp_i       (l2_rsp),
    .l2_rdata_i     (l2_rdata),
    .periph_req_o   (periph_req),
    .periph_we_o    (periph_we),
    .periph_offs_o  (periph_offs),
    .periph_wdata_o (periph_wdata),
    .periph_be_o    (periph_be),
    .periph_rsp_i   (periph_rsp),
    .periph_rdata_i (periph_rdata),
    .mst_rsp_o,
    .mst_rdata_o,
    .mst_err_o
  );

  l2_mem #(
    .L2_N_WORDS (L2_N_WORDS)
  ) i_l2_mem (
    .clk_i,
    .rst_i,
    .req_i   (l2_req),
    .we_i    (l2_we),
    .word_i  (l2_word),
    .wdata_i (l2_wdata),
    .be_i    (l2_be),
    .rsp_o   (l2_rsp),
    .rdata_o (l2_rdata)
  );

  soc_peripherals #(
    .N_CLUSTERS (N_CLUSTERS)
  ) i_periphs (
    .clk_i,
    .rst_i,
    .req_i    (periph_req),
    .we_i     (periph_we),
    .offs_i   (periph_offs),
    .wdata_i  (periph_wdata),
    .be_i     (periph_be),
    .rsp_o    (periph_rsp),
    .rdata_o  (periph_rdata),
    .cl_eoc_o
  );

endmodule

// ==== logic/pulp_soc_pkg.sv ====
/*
 * pulp soc package
 * bus widths, word types and the SoC address map shared by the
 * interconnect, its targets and the testbench model
 */

package pulp_soc_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [DATA_W/8-1:0] be_t;

  // L2 region, size comes from the L2_N_WORDS parameter
  localparam addr_t L2_BASE_ADDR = 32'h1C00_0000;

  // peripheral region
  localparam addr_t       PERIPH_BASE_ADDR = 32'h1A10_0000;
  localparam int unsigned PERIPH_N_BYTES   = 4096;

  // register byte offsets inside the peripheral region
  localparam int unsigned REG_EOC_OFFS     = 0;
  localparam int unsigned REG_INFO_OFFS    = 4;
  localparam int unsigned REG_SCRATCH_OFFS = 8;

endpackage

// ==== logic/soc_bus_arbiter.sv ====
/*
 * soc bus arbiter
 * one pending slot per master, round-robin grant onto the shared
 * bus and per-master outstanding tracking
 */

`timescale 1ns/1ns

module soc_bus_arbiter #(
  parameter  int unsigned N_CLUSTERS = 2,
  localparam int unsigned N_MST      = N_CLUSTERS + 1,
  localparam int unsigned MST_W      = $clog2(N_MST)
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                [N_MST-1:0]    mst_req_i,
  input  logic                [N_MST-1:0]    mst_we_i,
  input  pulp_soc_pkg::addr_t [N_MST-1:0]    mst_addr_i,
  input  pulp_soc_pkg::data_t [N_MST-1:0]    mst_wdata_i,
  input  pulp_soc_pkg::be_t   [N_MST-1:0]    mst_be_i,
  input  logic                [N_MST-1:0]    mst_rsp_i,
  output logic                               bus_req_o,
  output logic                               bus_we_o,
  output pulp_soc_pkg::addr_t                bus_addr_o,
  output pulp_soc_pkg::data_t                bus_wdata_o,
  output pulp_soc_pkg::be_t                  bus_be_o,
  output logic                [MST_W-1:0]    bus_mst_o,
  output logic                [N_MST-1:0]    mst_busy_o
);
  import pulp_soc_pkg::*;

  logic  [N_MST-1:0] pend_vld_q;
  logic  [N_MST-1:0] pend_we_q;
  addr_t [N_MST-1:0] pend_addr_q;
  data_t [N_MST-1:0] pend_wdata_q;
  be_t   [N_MST-1:0] pend_be_q;
  logic  [N_MST-1:0] busy_q;
  logic  [MST_W-1:0] last_q;
  logic              gnt_vld;
  logic  [MST_W-1:0] gnt_idx;
  logic  [N_MST-1:0] gnt_oh;

  // search starts one past the last granted master
  always_comb begin
    int idx;
    gnt_vld = 1'b0;
    gnt_idx = '0;
    for (int k = 1; k <= N_MST; k++) begin
      idx = (int'(last_q) + k) % N_MST;
      if (!gnt_vld && pend_vld_q[idx]) begin
        gnt_vld = 1'b1;
        gnt_idx = MST_W'(idx);
      end
    end
  end

  assign gnt_oh     = gnt_vld ? (N_MST'(1) << gnt_idx) : '0;
  assign mst_busy_o = busy_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_vld_q <= '0;
      busy_q     <= '0;
      last_q     <= MST_W'(N_MST - 1);
      bus_req_o  <= 1'b0;
    end else begin
      pend_vld_q <= (pend_vld_q & ~gnt_oh) | mst_req_i;
      // new request wins over a response in the same cycle
      busy_q     <= (busy_q & ~mst_rsp_i) | mst_req_i;
      bus_req_o  <= gnt_vld;
      if (gnt_vld) begin
        last_q <= gnt_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int m = 0; m < N_MST; m++) begin
      if (mst_req_i[m]) begin
        pend_we_q[m]    <= mst_we_i[m];
        pend_addr_q[m]  <= mst_addr_i[m];
        pend_wdata_q[m] <= mst_wdata_i[m];
        pend_be_q[m]    <= mst_be_i[m];
      end
    end
    if (gnt_vld) begin
      bus_we_o    <= pend_we_q[gnt_idx];
      bus_addr_o  <= pend_addr_q[gnt_idx];
      bus_wdata_o <= pend_wdata_q[gnt_idx];
      bus_be_o    <= pend_be_q[gnt_idx];
      bus_mst_o   <= gnt_idx;
    end
  end

  // only one request in flight per master
  a_one_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    (mst_req_i & busy_q & ~mst_rsp_i) == '0);

endmodule

// ==== logic/soc_bus_demux.sv ====
/*
 * soc bus demux
 * decodes the bus address into L2, peripherals or unmapped space and
 * routes the one-cycle response back to the issuing master
 */

`timescale 1ns/1ns

module soc_bus_demux #(
  parameter  int unsigned N_CLUSTERS = 2,
  parameter  int unsigned L2_N_WORDS = 256,
  localparam int unsigned N_MST      = N_CLUSTERS + 1,
  localparam int unsigned MST_W      = $clog2(N_MST),
  localparam int unsigned WORD_W     = $clog2(L2_N_WORDS),
  localparam int unsigned OFFS_W     = $clog2(pulp_soc_pkg::PERIPH_N_BYTES)
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               bus_req_i,
  input  logic                               bus_we_i,
  input  pulp_soc_pkg::addr_t                bus_addr_i,
  input  pulp_soc_pkg::data_t                bus_wdata_i,
  input  pulp_soc_pkg::be_t                  bus_be_i,
  input  logic                [MST_W-1:0]    bus_mst_i,
  output logic                               l2_req_o,
  output logic                               l2_we_o,
  output logic                [WORD_W-1:0]   l2_word_o,
  output pulp_soc_pkg::data_t                l2_wdata_o,
  output pulp_soc_pkg::be_t                  l2_be_o,
  input  logic                               l2_rsp_i,
  input  pulp_soc_pkg::data_t                l2_rdata_i,
  output logic                               periph_req_o,
  output logic                               periph_we_o,
  output logic                [OFFS_W-1:0]   periph_offs_o,
  output pulp_soc_pkg::data_t                periph_wdata_o,
  output pulp_soc_pkg::be_t                  periph_be_o,
  input  logic                               periph_rsp_i,
  input  pulp_soc_pkg::data_t                periph_rdata_i,
  output logic                [N_MST-1:0]    mst_rsp_o,
  output pulp_soc_pkg::data_t [N_MST-1:0]    mst_rdata_o,
  output logic                [N_MST-1:0]    mst_err_o
);
  import pulp_soc_pkg::*;

  localparam addr_t L2_N_BYTES = addr_t'(L2_N_WORDS * 4);

  addr_t             l2_offs;
  addr_t             periph_offs;
  logic              l2_hit;
  logic              periph_hit;
  logic              err_q;
  logic  [MST_W-1:0] mst_q;
  logic              rsp_vld;
  data_t             rsp_rdata;

  // offsets wrap below the base, so one compare per region
  assign l2_offs     = bus_addr_i - L2_BASE_ADDR;
  assign periph_offs = bus_addr_i - PERIPH_BASE_ADDR;
  assign l2_hit      = l2_offs < L2_N_BYTES;
  assign periph_hit  = periph_offs < addr_t'(PERIPH_N_BYTES);

  assign l2_req_o   = bus_req_i & l2_hit;
  assign l2_we_o    = bus_we_i;
  assign l2_word_o  = l2_offs[WORD_W+1:2];
  assign l2_wdata_o = bus_wdata_i;
  assign l2_be_o    = bus_be_i;

  assign periph_req_o   = bus_req_i & periph_hit;
  assign periph_we_o    = bus_we_i;
  assign periph_offs_o  = {periph_offs[OFFS_W-1:2], 2'b00};
  assign periph_wdata_o = bus_wdata_i;
  assign periph_be_o    = bus_be_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bus_req_i & ~l2_hit & ~periph_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i) begin
      mst_q <= bus_mst_i;
    end
  end

  // unmapped accesses answer with zero data
  assign rsp_vld = l2_rsp_i | periph_rsp_i | err_q;

  always_comb begin
    rsp_rdata = '0;
    if (l2_rsp_i) begin
      rsp_rdata = l2_rdata_i;
    end else if (periph_rsp_i) begin
      rsp_rdata = periph_rdata_i;
    end
  end

  always_comb begin
    logic sel;
    for (int m = 0; m < N_MST; m++) begin
      sel            = rsp_vld && (mst_q == MST_W'(m));
      mst_rsp_o[m]   = sel;
      mst_rdata_o[m] = sel ? rsp_rdata : '0;
      mst_err_o[m]   = sel & err_q;
    end
  end

  a_single_target_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
    !(l2_rsp_i && periph_rsp_i));

endmodule

// ==== logic/soc_peripherals.sv ====
/*
 * soc peripherals
 * end-of-computation, cluster info and scratch registers,
 * one-cycle response to every access
 */

`timescale 1ns/1ns

module soc_peripherals #(
  parameter  int unsigned N_CLUSTERS = 2,
  localparam int unsigned OFFS_W     = $clog2(pulp_soc_pkg::PERIPH_N_BYTES)
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic             [OFFS_W-1:0] offs_i,
  input  pulp_soc_pkg::data_t           wdata_i,
  input  pulp_soc_pkg::be_t             be_i,
  output logic                          rsp_o,
  output pulp_soc_pkg::data_t           rdata_o,
  output logic         [N_CLUSTERS-1:0] cl_eoc_o
);
  import pulp_soc_pkg::*;

  logic  [N_CLUSTERS-1:0] eoc_q;
  data_t                  scratch_q;
  data_t                  rd_val;

  always_comb begin
    case (offs_i)
      OFFS_W'(REG_EOC_OFFS):     rd_val = data_t'(eoc_q);
      OFFS_W'(REG_INFO_OFFS):    rd_val = data_t'(N_CLUSTERS);
      OFFS_W'(REG_SCRATCH_OFFS): rd_val = scratch_q;
      default:                   rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      eoc_q     <= '0;
      scratch_q <= '0;
      rsp_o     <= 1'b0;
    end else begin
      rsp_o <= req_i;
      if (req_i && we_i && offs_i == OFFS_W'(REG_EOC_OFFS)) begin
        // one eoc bit per cluster, gated by its byte lane
        for (int i = 0; i < N_CLUSTERS; i++) begin
          if (be_i[i / 8]) begin
            eoc_q[i] <= wdata_i[i];
          end
        end
      end
      if (req_i && we_i && offs_i == OFFS_W'(REG_SCRATCH_OFFS)) begin
        for (int b = 0; b < DATA_W / 8; b++) begin
          if (be_i[b]) begin
            scratch_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rd_val;
    end
  end

  assign cl_eoc_o = eoc_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pulp_soc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_pulp_soc -f files.f -o Vtb_pulp_soc
./obj_dir/Vtb_pulp_soc > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi

// ==== testbench/soc_model.svh ====
/*
 * soc reference model
 * L2 contents, peripheral registers and the address map as the
 * masters see them, updated in bus order as responses arrive
 */

`ifndef SOC_MODEL_SVH
`define SOC_MODEL_SVH

data_t                  l2_model [L2_N_WORDS];
logic  [N_CLUSTERS-1:0] eoc_model;
data_t                  scratch_model;

function automatic bit in_l2(input addr_t addr);
  return addr >= L2_BASE_ADDR && addr < L2_BASE_ADDR + addr_t'(L2_N_WORDS * 4);
endfunction

function automatic bit in_periph(input addr_t addr);
  return addr >= PERIPH_BASE_ADDR && addr < PERIPH_BASE_ADDR + addr_t'(PERIPH_N_BYTES);
endfunction

function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be);
  data_t res;
  res = old;
  for (int b = 0; b < 4; b++) begin
    if (be[b]) begin
      res[8*b +: 8] = wdata[8*b +: 8];
    end
  end
  return res;
endfunction

task automatic model_reset();
  for (int w = 0; w < L2_N_WORDS; w++) begin
    l2_model[w] = '0;
  end
  eoc_model     = '0;
  scratch_model = '0;
endtask

// rdata is the value before any write of this access
task automatic model_access(input logic we, input addr_t addr, input data_t wdata,
                            input be_t be, output data_t rdata, output logic err);
  int    word;
  addr_t offs;
  rdata = '0;
  err   = 1'b0;
  if (in_l2(addr)) begin
    word  = int'((addr - L2_BASE_ADDR) >> 2);
    rdata = l2_model[word];
    if (we) begin
      l2_model[word] = merge_bytes(l2_model[word], wdata, be);
    end
  end else if (in_periph(addr)) begin
    offs = (addr - PERIPH_BASE_ADDR) & 32'hFFC;
    if (offs == addr_t'(REG_EOC_OFFS)) begin
      rdata = data_t'(eoc_model);
      for (int i = 0; i < N_CLUSTERS; i++) begin
        // each eoc bit sits in byte lane i/8
        if (we && be[i / 8]) begin
          eoc_model[i] = wdata[i];
        end
      end
    end else if (offs == addr_t'(REG_INFO_OFFS)) begin
      rdata = data_t'(N_CLUSTERS);
    end else if (offs == addr_t'(REG_SCRATCH_OFFS)) begin
      rdata = scratch_model;
      if (we) begin
        scratch_model = merge_bytes(scratch_model, wdata, be);
      end
    end
  end else begin
    err = 1'b1;
  end
endtask

`endif

// ==== testbench/tb_pulp_soc.sv ====
/*
 * pulp soc testbench
 * random single-word traffic from all clusters and the host, checked
 * against a reference model of L2, the registers and the address map
 */

`timescale 1ns/1ns

module tb_pulp_soc;
  import pulp_soc_pkg::*;

  localparam int unsigned N_CLUSTERS      = 2;
  localparam int unsigned N_MST           = N_CLUSTERS + 1;
  localparam int unsigned L2_N_WORDS      = 256;
  localparam int unsigned L2_SPAN         = L2_N_WORDS / N_MST;
  localparam int          CLK_PERIOD      = 4;
  localparam int          REQS_PER_TEST   = 150;
  localparam int          N_TESTS         = 5;
  localparam int          WATCHDOG_CYCLES = 16 + N_TESTS * REQS_PER_TEST * (N_MST + 2) + 200;
  localparam int          MIX_L2          = 0;
  localparam int          MIX_PERIPH      = 1;
  localparam int          MIX_UNMAPPED    = 2;
  localparam int          MIX_MIXED       = 3;

  `include "soc_model.svh"

  logic                             clk_i;
  logic                             rst_i;
  logic              [N_MST-1:0]    mst_req_i;
  logic              [N_MST-1:0]    mst_we_i;
  addr_t             [N_MST-1:0]    mst_addr_i;
  data_t             [N_MST-1:0]    mst_wdata_i;
  be_t               [N_MST-1:0]    mst_be_i;
  logic              [N_MST-1:0]    mst_rsp_o;
  data_t             [N_MST-1:0]    mst_rdata_o;
  logic              [N_MST-1:0]    mst_err_o;
  logic              [N_CLUSTERS-1:0] cl_eoc_o;
  logic              [N_CLUSTERS-1:0] cl_busy_o;

  // request in flight per master
  logic  [N_MST-1:0] in_flight;
  logic  [N_MST-1:0] fl_we;
  addr_t             fl_addr  [N_MST];
  data_t             fl_wdata [N_MST];
  be_t               fl_be    [N_MST];
  int                fl_cycle [N_MST];

  integer seed;
  string  cur_test;
  int     cycle;
  int     issued;
  int     test_errs;
  int     err_cnt;
  int     tests_run;
  int     tests_failed;

  pulp_soc #(
    .N_CLUSTERS (N_CLUSTERS),
    .L2_N_WORDS (L2_N_WORDS)
  ) pulp_soc_i (
    .clk_i,
    .rst_i,
    .mst_req_i,
    .mst_we_i,
    .mst_addr_i,
    .mst_wdata_i,
    .mst_be_i,
    .mst_rsp_o,
    .mst_rdata_o,
    .mst_err_o,
    .cl_eoc_o,
    .cl_busy_o
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run stopped after %0d cycles, requests still in flight %b",
             WATCHDOG_CYCLES, in_flight);
    $display("Done: errors found");
    $finish;
  end

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic count_error();
    test_errs++;
    err_cnt++;
  endtask

  task automatic issue_request(input int m, input int mix);
    int    cls;
    int    offs;
    logic  we;
    addr_t addr;
    cls = rand_below(16);
    we  = rand_below(2) == 1;
    if (mix == MIX_PERIPH || (mix == MIX_MIXED && cls >= 12 && cls < 15)) begin
      case (rand_below(6))
        0: offs = REG_INFO_OFFS;
        1: begin
          offs = REG_SCRATCH_OFFS;
          we   = 1'b0;
        end
        // only the host writes scratch
        2: begin
          offs = REG_SCRATCH_OFFS;
          we   = (m == N_MST - 1);
        end
        3: begin
          offs = REG_EOC_OFFS;
          we   = 1'b1;
        end
        4: begin
          offs = REG_EOC_OFFS;
          we   = 1'b0;
        end
        default: offs = 12 + 4 * rand_below(1021);
      endcase
      addr = PERIPH_BASE_ADDR + addr_t'(offs);
    end else if ((mix == MIX_UNMAPPED && cls < 8) || (mix == MIX_MIXED && cls == 15)) begin
      case (rand_below(3))
        0: addr = L2_BASE_ADDR + addr_t'(L2_N_WORDS * 4) + addr_t'(4 * rand_below(4096));
        1: addr = PERIPH_BASE_ADDR + addr_t'(PERIPH_N_BYTES) + addr_t'(4 * rand_below(4096));
        default: addr = addr_t'(4 * rand_below(1 << 20));
      endcase
    end else begin
      // each master keeps to its own slice of L2
      addr = L2_BASE_ADDR + addr_t'(4 * (m * L2_SPAN + rand_below(L2_SPAN)));
    end
    mst_req_i[m]   = 1'b1;
    mst_we_i[m]    = we;
    mst_addr_i[m]  = addr;
    mst_wdata_i[m] = data_t'($random(seed));
    mst_be_i[m]    = be_t'(rand_below(16));
    in_flight[m]   = 1'b1;
    fl_we[m]       = we;
    fl_addr[m]     = addr;
    fl_wdata[m]    = mst_wdata_i[m];
    fl_be[m]       = mst_be_i[m];
    fl_cycle[m]    = cycle;
    issued++;
  endtask

  task automatic collect_responses();
    data_t exp_rdata;
    logic  exp_err;
    int    lat;
    for (int m = 0; m < N_MST; m++) begin
      if (mst_rsp_o[m]) begin
        assert (in_flight[m]) else begin
          $display("error in %s: master %0d got a response with no request in flight",
                   cur_test, m);
          count_error();
        end
        if (in_flight[m]) begin
          model_access(fl_we[m], fl_addr[m], fl_wdata[m], fl_be[m], exp_rdata, exp_err);
          lat = cycle - fl_cycle[m] - 1;
          assert (lat >= 2 && lat <= N_MST + 1) else begin
            $display("error in %s: master %0d answered after %0d cycles, outside 2 to %0d",
                     cur_test, m, lat, N_MST + 1);
            count_error();
          end
          assert (mst_err_o[m] == exp_err) else begin
            $display("mismatch %s: master %0d addr %h err expected %b actual %b",
                     cur_test, m, fl_addr[m], exp_err, mst_err_o[m]);
            count_error();
          end
          // write data returned by a target is not defined
          if (!fl_we[m] || exp_err) begin
            assert (mst_rdata_o[m] == exp_rdata) else begin
              $display("mismatch %s: master %0d addr %h rdata expected %h actual %h",
                       cur_test, m, fl_addr[m], exp_rdata, mst_rdata_o[m]);
              count_error();
            end
          end
          in_flight[m] = 1'b0;
        end
      end
    end
  endtask

  task automatic step_cycle(input int mix, input bit lockstep);
    logic all_idle;
    @(posedge clk_i);
    #1;
    cycle++;
    mst_req_i = '0;
    // busy runs from the cycle after the request through the response
    for (int c = 0; c < N_CLUSTERS; c++) begin
      assert (cl_busy_o[c] == in_flight[c]) else begin
        $display("mismatch %s: cl_busy_o[%0d] expected %b actual %b",
                 cur_test, c, in_flight[c], cl_busy_o[c]);
        count_error();
      end
    end
    collect_responses();
    assert (cl_eoc_o == eoc_model) else begin
      $display("mismatch %s: cl_eoc_o expected %b actual %b", cur_test, eoc_model, cl_eoc_o);
      count_error();
    end
    if (issued < REQS_PER_TEST) begin
      // in lockstep every master issues in the same cycle once all are idle
      all_idle = (in_flight == '0);
      for (int m = 0; m < N_MST; m++) begin
        if (lockstep ? all_idle : (!in_flight[m] && rand_below(4) != 0)) begin
          issue_request(m, mix);
        end
      end
    end
  endtask

  task automatic run_test(input string name, input int mix, input bit lockstep);
    cur_test  = name;
    test_errs = 0;
    issued    = 0;
    while (issued < REQS_PER_TEST || in_flight != '0) begin
      step_cycle(mix, lockstep);
    end
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("test %s: %0d requests, %0d errors", name, issued, test_errs);
  endtask

  initial begin : main
    seed         = 32'hb1a1;
    rst_i        = 1'b1;
    mst_req_i    = '0;
    mst_we_i     = '0;
    mst_addr_i   = '0;
    mst_wdata_i  = '0;
    mst_be_i     = '0;
    in_flight    = '0;
    cycle        = 0;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    model_reset();

    cur_test  = "reset";
    test_errs = 0;
    repeat (16) @(posedge clk_i);
    #1;
    assert (mst_rsp_o == '0 && cl_busy_o == '0 && cl_eoc_o == '0) else begin
      $display("error in reset: outputs not cleared, rsp %b busy %b eoc %b",
               mst_rsp_o, cl_busy_o, cl_eoc_o);
      count_error();
    end
    rst_i = 1'b0;
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("test reset: %0d errors", test_errs);

    run_test("l2_rw", MIX_L2, 1'b0);
    run_test("periph_regs", MIX_PERIPH, 1'b0);
    run_test("unmapped", MIX_UNMAPPED, 1'b0);
    run_test("mixed", MIX_MIXED, 1'b0);
    run_test("all_at_once", MIX_MIXED, 1'b1);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
